/* dv/cam_switch_tb.sv */
`timescale 1ns/1ps
`include "cam_switch_defines.svh"

module cam_switch_tb
    import cam_switch_pkg::*;
();

    localparam int NM         = `NUM_SRC - 1;
    localparam int FRAME      = `H_TOTAL * `V_TOTAL;
    localparam int N_TESTS    = 8;
    localparam int PRESS_LEN  = 16;                             // 8 cycles high, then 8 low.
    localparam int GLITCH_AT  = `V_ACT * `H_TOTAL;              // first blank line.
    localparam int SEL_AT     = (`V_TOTAL - 1) * `H_TOTAL + 2;  // second vsync cycle seen.
    localparam int TIMEOUT_NS = ((N_TESTS + 3) * FRAME + 20) * 8;

    typedef struct packed {
        logic [3:0]    presses;
        logic [3:0]    glitch_len;
        logic [NM-1:0] de_off;      // minor sources with their enable held low.
        src_idx_t      exp_src;
    } test_t;

    test_t                     tests [N_TESTS];
    logic                      main_clk;
    logic                      rstn;
    logic                      main_hsync;
    logic                      main_vsync;
    logic                      main_de;
    pixel_t                    main_rgb;
    logic [NM-1:0]             minor_hsync;
    logic [NM-1:0]             minor_vsync;
    logic [NM-1:0]             minor_de;
    pixel_t [NM-1:0]           minor_rgb;
    logic                      key;
    logic                      out_hsync;
    logic                      out_vsync;
    logic                      out_de;
    logic [$clog2(`H_ACT)-1:0] out_x;
    logic [$clog2(`V_ACT)-1:0] out_y;
    pixel_t                    out_rgb;
    src_idx_t                  out_sel;

    // driven main inputs and expected pixels, indexed by cycle modulo 8.
    logic   hist_hs  [8];
    logic   hist_vs  [8];
    logic   hist_de  [8];
    int     hist_x   [8];
    int     hist_y   [8];
    pixel_t hist_rgb [8];
    int     n_checks;
    int     n_errors;

    cam_switch_top DUT (
        .i_main_clk    (main_clk   ),
        .i_rstn        (rstn       ),
        .i_main_hsync  (main_hsync ),
        .i_main_vsync  (main_vsync ),
        .i_main_de     (main_de    ),
        .i_main_rgb    (main_rgb   ),
        .i_minor_hsync (minor_hsync),
        .i_minor_vsync (minor_vsync),
        .i_minor_de    (minor_de   ),
        .i_minor_rgb   (minor_rgb  ),
        .i_key         (key        ),
        .o_hsync       (out_hsync  ),
        .o_vsync       (out_vsync  ),
        .o_de          (out_de     ),
        .o_x           (out_x      ),
        .o_y           (out_y      ),
        .o_rgb         (out_rgb    ),
        .o_sel         (out_sel    )
    );

    initial begin
        main_clk = 1'b0;
    end

    always #4 main_clk = ~main_clk;

    // ======================================================================
    // Frame model and stimulus table.
    // ======================================================================

    // entry i acts during frame i, its source is shown in frame i+1.
    task automatic load_table();
        tests[0] = '{4'd1, 4'd0, 2'b00, 2'd1};
        tests[1] = '{4'd0, 4'd3, 2'b00, 2'd1};
        tests[2] = '{4'd1, 4'd4, 2'b00, 2'd2};
        tests[3] = '{4'd1, 4'd0, 2'b00, 2'd0};
        tests[4] = '{4'd3, 4'd0, 2'b00, 2'd0};
        tests[5] = '{4'd2, 4'd0, 2'b10, 2'd2};
        tests[6] = '{4'd2, 4'd1, 2'b01, 2'd1};
        tests[7] = '{4'd2, 4'd2, 2'b00, 2'd0};
    endtask

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [2:0] timing_at(input int rel);  // {hsync, vsync, de}
        int h;
        int v;
        h = rel % `H_TOTAL;
        v = rel / `H_TOTAL;
        return {h > `H_ACT && h < `H_ACT + 3, v == `V_TOTAL - 1, h < `H_ACT && v < `V_ACT};
    endfunction

    function automatic pixel_t pattern(input int src, input int rel);
        pixel_t px;
        px.r = 8'(src);
        px.g = 8'(rel / `H_TOTAL);
        px.b = 8'(rel % `H_TOTAL);
        return px;
    endfunction

    function automatic src_idx_t src_of_frame(input int f);
        if (f == 0) begin
            return '0;
        end else if (f > N_TESTS) begin
            return tests[N_TESTS-1].exp_src;
        end
        return tests[f-1].exp_src;
    endfunction

    function automatic logic de_held_low(input int f, input int k);
        return (f >= 1) && (f <= N_TESTS) && (k >= 1) && tests[f-1].de_off[k-1];
    endfunction

    function automatic logic key_level(input int f, input int rel, input int gpos);
        logic lvl;
        lvl = 1'b0;
        if (f < N_TESTS) begin
            if (rel < int'(tests[f].presses) * PRESS_LEN && rel % PRESS_LEN < PRESS_LEN / 2) begin
                lvl = 1'b1;
            end
            if (rel >= gpos && rel < gpos + int'(tests[f].glitch_len)) begin
                lvl = 1'b1;
            end
        end
        return lvl;
    endfunction

    task automatic drive_cycle(input int gc, input int gpos);
        int         f;
        int         rel;
        int         p;
        int         slot;
        logic [2:0] t;
        src_idx_t   src;
        f          = gc / FRAME;
        rel        = gc % FRAME;
        t          = timing_at(rel);
        main_hsync = t[2];
        main_vsync = t[1];
        main_de    = t[0];
        main_rgb   = pattern(0, rel);
        for (int k = 1; k <= NM; k++) begin
            p                = gc + k;  // minor source k leads by k cycles.
            t                = timing_at(p % FRAME);
            minor_hsync[k-1] = t[2];
            minor_vsync[k-1] = t[1];
            minor_de[k-1]    = t[0] && !de_held_low(p / FRAME, k);
            minor_rgb[k-1]   = pattern(k, p % FRAME);
        end
        key            = key_level(f, rel, gpos);
        slot           = gc % 8;
        src            = src_of_frame(f);
        hist_hs[slot]  = main_hsync;
        hist_vs[slot]  = main_vsync;
        hist_de[slot]  = main_de;
        hist_x[slot]   = rel % `H_TOTAL;
        hist_y[slot]   = rel / `H_TOTAL;
        if (de_held_low(f, int'(src))) begin
            hist_rgb[slot] = '1;  // fill colour on underrun.
        end else begin
            hist_rgb[slot] = pattern(int'(src), rel);
        end
    endtask

    // ======================================================================
    // Checks.
    // ======================================================================

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        assert (got === exp) else begin
            n_errors++;
            $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_cycle(input int gc);
        int       slot;
        int       rel;
        src_idx_t exp_sel;
        slot    = (gc + 8 - `PIX_DELAY) % 8;
        rel     = gc % FRAME;
        exp_sel = (rel >= SEL_AT) ? src_of_frame(gc / FRAME + 1) : src_of_frame(gc / FRAME);
        check_value("o_hsync", 32'(out_hsync), 32'(hist_hs[slot]));
        check_value("o_vsync", 32'(out_vsync), 32'(hist_vs[slot]));
        check_value("o_de", 32'(out_de), 32'(hist_de[slot]));
        check_value("o_sel", 32'(out_sel), 32'(exp_sel));
        if (hist_de[slot]) begin
            check_value("o_x", 32'(out_x), 32'(hist_x[slot]));
            check_value("o_y", 32'(out_y), 32'(hist_y[slot]));
            check_value("o_rgb", 32'(out_rgb), 32'(hist_rgb[slot]));
        end
    endtask

    initial begin : stimulus
        int          f;
        int          c;
        int          gc;
        int          gpos;
        int          err_before;
        logic [31:0] rnd;
        load_table();
        n_checks    = 0;
        n_errors    = 0;
        rstn        = 1'b0;
        key         = 1'b0;
        main_hsync  = 1'b0;
        main_vsync  = 1'b0;
        main_de     = 1'b0;
        main_rgb    = '0;
        minor_hsync = '0;
        minor_vsync = '0;
        minor_de    = '0;
        minor_rgb   = '0;
        for (int i = 0; i < 8; i++) begin
            hist_hs[i]  = 1'b0;
            hist_vs[i]  = 1'b0;
            hist_de[i]  = 1'b0;
            hist_x[i]   = 0;
            hist_y[i]   = 0;
            hist_rgb[i] = '0;
        end
        repeat (10) @(negedge main_clk);
        rstn = 1'b1;
        @(negedge main_clk);
        check_value("o_de", 32'(out_de), 32'd0);
        check_value("o_sel", 32'(out_sel), 32'd0);
        rnd = 32'h18a0;
        gc  = 0;
        for (f = 0; f <= N_TESTS; f++) begin
            rnd        = next_random(rnd);
            gpos       = GLITCH_AT + int'(rnd[2:0]);
            err_before = n_errors;
            for (c = 0; c < FRAME; c++) begin
                @(negedge main_clk);
                check_cycle(gc);
                drive_cycle(gc, gpos);
                gc++;
            end
            $display("frame %0d: source %0d, %0d errors, %s", f, src_of_frame(f),
                     n_errors - err_before, (n_errors == err_before) ? "ok" : "failed");
        end
        $display("frames run: %0d, checks: %0d, errors: %0d", N_TESTS + 1, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("timeout, the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Errors found");
        $finish;
    end

endmodule

/* hw/cam_switch_defines.svh */
`ifndef CAM_SWITCH_DEFINES_SVH
`define CAM_SWITCH_DEFINES_SVH

// ==========================================================================
// Source count and frame geometry.
// ==========================================================================

`define NUM_SRC   3     // main camera plus the minor cameras.

`define H_ACT     8     // active pixels per line.
`define V_ACT     4     // active lines per frame.
`define H_TOTAL   12    // cycles per line, blanking included.
`define V_TOTAL   6     // lines per frame, blanking included.

// ==========================================================================
// Pipeline, key filter and buffering.
// ==========================================================================

`define PIX_DELAY 5     // main input to output, in cycles.
`define KEY_TICK  5     // stable cycles before a key level counts.
`define BUF_DEPTH 16    // words per line buffer, a power of two.

`endif

/* hw/cam_switch_pkg.sv */
`include "cam_switch_defines.svh"

package cam_switch_pkg;

    // ======================================================================
    // Video payload and source numbering.
    // ======================================================================

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    typedef logic [$clog2(`NUM_SRC)-1:0] src_idx_t;  // 0 is the main camera.

    // ======================================================================
    // Key filter.
    // ======================================================================

    typedef enum logic [1:0] {
        KEY_RELEASED,   // key low and settled.
        KEY_PRESSING,   // key went high, waiting for it to hold.
        KEY_HELD,       // press accepted.
        KEY_RELEASING   // key went low, waiting for it to hold.
    } key_state_e;

endpackage

/* hw/cam_switch_top.sv */
`timescale 1ns/1ps
`include "cam_switch_defines.svh"

module cam_switch_top
    import cam_switch_pkg::*;
(
    input  logic                      i_main_clk,
    input  logic                      i_rstn,
    input  logic                      i_main_hsync,
    input  logic                      i_main_vsync,
    input  logic                      i_main_de,
    input  pixel_t                    i_main_rgb,
    input  logic [`NUM_SRC-2:0]       i_minor_hsync,
    input  logic [`NUM_SRC-2:0]       i_minor_vsync,
    input  logic [`NUM_SRC-2:0]       i_minor_de,
    input  pixel_t [`NUM_SRC-2:0]     i_minor_rgb,
    input  logic                      i_key,
    output logic                      o_hsync,
    output logic                      o_vsync,
    output logic                      o_de,
    output logic [$clog2(`H_ACT)-1:0] o_x,
    output logic [$clog2(`V_ACT)-1:0] o_y,
    output pixel_t                    o_rgb,
    output src_idx_t                  o_sel
);

    pixel_t                 main_rgb_d;
    logic                   rd_stb;
    pixel_t [`NUM_SRC-2:0]  buf_rgb;
    logic   [`NUM_SRC-2:0]  buf_empty;

    key_switch u_key_switch (
        .i_main_clk   (i_main_clk  ),
        .i_rstn       (i_rstn      ),
        .i_key        (i_key       ),
        .i_main_vsync (i_main_vsync),
        .o_sel        (o_sel       )
    );

    timing_delay u_timing_delay (
        .i_main_clk (i_main_clk  ),
        .i_rstn     (i_rstn      ),
        .i_hsync    (i_main_hsync),
        .i_vsync    (i_main_vsync),
        .i_de       (i_main_de   ),
        .i_rgb      (i_main_rgb  ),
        .o_hsync    (o_hsync     ),
        .o_vsync    (o_vsync     ),
        .o_de       (o_de        ),
        .o_rgb      (main_rgb_d  ),
        .o_x        (o_x         ),
        .o_y        (o_y         ),
        .o_rd_stb   (rd_stb      )
    );

    // ======================================================================
    // One line buffer per minor camera, filled only while it is selected.
    // ======================================================================

    for (genvar k = 0; k < `NUM_SRC - 1; k++) begin : g_minor
        wire wr_en = i_minor_de[k] && !i_minor_hsync[k]
                     && (o_sel == src_idx_t'(k + 1));  // pixels never taken in line sync.

        line_buffer u_line_buffer (
            .i_main_clk (i_main_clk      ),
            .i_rstn     (i_rstn          ),
            .i_wr_clr   (i_minor_vsync[k]),
            .i_wr_en    (wr_en           ),
            .i_wr_data  (i_minor_rgb[k]  ),
            .i_rd_clr   (i_main_vsync    ),
            .i_rd_en    (rd_stb          ),
            .o_rd_data  (buf_rgb[k]      ),
            .o_empty    (buf_empty[k]    )
        );
    end

    pixel_select u_pixel_select (
        .i_sel       (o_sel     ),
        .i_main_rgb  (main_rgb_d),
        .i_buf_rgb   (buf_rgb   ),
        .i_buf_empty (buf_empty ),
        .o_rgb       (o_rgb     )
    );

endmodule

/* hw/key_switch.sv */
`timescale 1ns/1ps
`include "cam_switch_defines.svh"

module key_switch
    import cam_switch_pkg::*;
(
    input  logic     i_main_clk,
    input  logic     i_rstn,
    input  logic     i_key,
    input  logic     i_main_vsync,
    output src_idx_t o_sel
);

    localparam int       CNT_W    = $clog2(`KEY_TICK + 1);
    localparam src_idx_t LAST_SRC = src_idx_t'(`NUM_SRC - 1);

    key_state_e       state;
    logic [CNT_W-1:0] tick_cnt;
    logic             press;
    src_idx_t         pend_sel;
    logic             vsync_q;

    // ======================================================================
    // Debounce.
    // ======================================================================

    always_ff @(posedge i_main_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            state    <= KEY_RELEASED;
            tick_cnt <= '0;
            press    <= 1'b0;
        end else begin
            press <= 1'b0;
            case (state)
                KEY_RELEASED: begin
                    if (i_key) begin
                        state    <= KEY_PRESSING;
                        tick_cnt <= CNT_W'(1);  // the first high sample counts.
                    end
                end
                KEY_PRESSING: begin
                    if (!i_key) begin
                        state <= KEY_RELEASED;  // bounce, start over.
                    end else if (tick_cnt == CNT_W'(`KEY_TICK - 1)) begin
                        state <= KEY_HELD;
                        press <= 1'b1;  // one pulse per accepted press.
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                KEY_HELD: begin
                    if (!i_key) begin
                        state    <= KEY_RELEASING;
                        tick_cnt <= CNT_W'(1);
                    end
                end
                KEY_RELEASING: begin
                    if (i_key) begin
                        state <= KEY_HELD;
                    end else if (tick_cnt == CNT_W'(`KEY_TICK - 1)) begin
                        state <= KEY_RELEASED;
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: state <= KEY_RELEASED;
            endcase
        end
    end

    // ======================================================================
    // Pending index, applied in the main vertical sync.
    // ======================================================================

    always_ff @(posedge i_main_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            pend_sel <= '0;
            vsync_q  <= 1'b0;
            o_sel    <= '0;
        end else begin
            vsync_q <= i_main_vsync;
            if (press) begin
                pend_sel <= (pend_sel == LAST_SRC) ? '0 : pend_sel + 1'b1;
            end
            if (vsync_q && i_main_vsync) begin
                o_sel <= pend_sel;  // second cycle of sync, so no frame is cut.
            end
        end
    end

    a_sel_range: assert property (@(posedge i_main_clk) disable iff (!i_rstn)
        int'(o_sel) < `NUM_SRC);

endmodule

/* hw/line_buffer.sv */
`timescale 1ns/1ps
`include "cam_switch_defines.svh"

module line_buffer
    import cam_switch_pkg::*;
(
    input  logic   i_main_clk,
    input  logic   i_rstn,
    input  logic   i_wr_clr,
    input  logic   i_wr_en,
    input  pixel_t i_wr_data,
    input  logic   i_rd_clr,
    input  logic   i_rd_en,
    output pixel_t o_rd_data,
    output logic   o_empty
);

    localparam int AW = $clog2(`BUF_DEPTH);

    pixel_t      mem [`BUF_DEPTH];
    logic [AW:0] wr_ptr;   // extra bit tells full from empty.
    logic [AW:0] rd_ptr;
    logic        full;
    logic        empty;
    logic        wr_ok;
    logic        rd_ok;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign wr_ok = i_wr_en && !full && !i_wr_clr;
    assign rd_ok = i_rd_en && !empty && !i_rd_clr;

    // ======================================================================
    // Write side, reset by the source's own vertical sync.
    // ======================================================================

    always_ff @(posedge i_main_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            wr_ptr <= '0;
        end else if (i_wr_clr) begin
            wr_ptr <= '0;
        end else if (wr_ok) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge i_main_clk) begin
        if (wr_ok) begin
            mem[wr_ptr[AW-1:0]] <= i_wr_data;
        end
    end

    // ======================================================================
    // Read side, reset by the main vertical sync.
    // ======================================================================

    always_ff @(posedge i_main_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            rd_ptr  <= '0;
            o_empty <= 1'b1;
        end else begin
            if (i_rd_clr) begin
                rd_ptr <= '0;
            end else if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (i_rd_en) begin
                o_empty <= empty || i_rd_clr;  // underrun seen by this read.
            end
        end
    end

    always_ff @(posedge i_main_clk) begin
        if (i_rd_en) begin
            o_rd_data <= mem[rd_ptr[AW-1:0]];
        end
    end

    // a minor camera may lead by at most one buffer depth.
    a_no_overflow: assert property (@(posedge i_main_clk) disable iff (!i_rstn)
        (i_wr_en && !i_wr_clr) |-> !full);

    a_rd_data_known: assert property (@(posedge i_main_clk) disable iff (!i_rstn)
        rd_ok |=> !$isunknown(o_rd_data));

endmodule

/* hw/pixel_select.sv */
`timescale 1ns/1ps
`include "cam_switch_defines.svh"

module pixel_select
    import cam_switch_pkg::*;
(
    input  src_idx_t                   i_sel,
    input  pixel_t                     i_main_rgb,
    input  pixel_t [`NUM_SRC-2:0]      i_buf_rgb,
    input  logic   [`NUM_SRC-2:0]      i_buf_empty,
    output pixel_t                     o_rgb
);

    localparam pixel_t FILL_RGB = '1;  // shown when a minor buffer runs dry.

    // ======================================================================
    // Source mux. Minor source k sits in buffer slot k-1.
    // ======================================================================

    always_comb begin
        o_rgb = i_main_rgb;
        for (int k = 1; k < `NUM_SRC; k++) begin
            if (i_sel == src_idx_t'(k)) begin
                if (i_buf_empty[k-1]) begin
                    o_rgb = FILL_RGB;  // the read found nothing to show.
                end else begin
                    o_rgb = i_buf_rgb[k-1];
                end
            end
        end
    end

endmodule

/* hw/timing_delay.sv */
`timescale 1ns/1ps
`include "cam_switch_defines.svh"

module timing_delay
    import cam_switch_pkg::*;
(
    input  logic                      i_main_clk,
    input  logic                      i_rstn,
    input  logic                      i_hsync,
    input  logic                      i_vsync,
    input  logic                      i_de,
    input  pixel_t                    i_rgb,
    output logic                      o_hsync,
    output logic                      o_vsync,
    output logic                      o_de,
    output pixel_t                    o_rgb,
    output logic [$clog2(`H_ACT)-1:0] o_x,
    output logic [$clog2(`V_ACT)-1:0] o_y,
    output logic                      o_rd_stb
);

    localparam int D = `PIX_DELAY;

    logic [D-1:0] hs_sr;
    logic [D-1:0] vs_sr;
    logic [D-1:0] de_sr;
    pixel_t       rgb_sr [D];
    logic         line_end;

    always_ff @(posedge i_main_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            hs_sr <= '0;
            vs_sr <= '0;
            de_sr <= '0;
        end else begin
            hs_sr <= {hs_sr[D-2:0], i_hsync};
            vs_sr <= {vs_sr[D-2:0], i_vsync};
            de_sr <= {de_sr[D-2:0], i_de};
        end
    end

    always_ff @(posedge i_main_clk) begin
        rgb_sr[0] <= i_rgb;
        for (int i = 1; i < D; i++) begin
            rgb_sr[i] <= rgb_sr[i-1];
        end
    end

    assign o_hsync  = hs_sr[D-1];
    assign o_vsync  = vs_sr[D-1];
    assign o_de     = de_sr[D-1];
    assign o_rgb    = rgb_sr[D-1];
    assign o_rd_stb = de_sr[D-2];  // one stage early, the buffers register their data.

    assign line_end = o_de && !de_sr[D-2];  // last active pixel of the line.

    // output coordinates
    always_ff @(posedge i_main_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_x <= '0;
            o_y <= '0;
        end else begin
            o_x <= o_de ? o_x + 1'b1 : '0;
            if (o_vsync) begin
                o_y <= '0;
            end else if (line_end) begin
                o_y <= o_y + 1'b1;
            end
        end
    end

endmodule

/* list.f */
+incdir+hw
hw/cam_switch_pkg.sv
hw/key_switch.sv
hw/timing_delay.sv
hw/line_buffer.sv
hw/pixel_select.sv
hw/cam_switch_top.sv
dv/cam_switch_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds and runs the camera selector testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module cam_switch_tb \
    -o cam_switch_sim > "$LOG" 2>&1 \
    && ./obj_dir/cam_switch_sim >> "$LOG" 2>&1 \
    || { echo "build or simulation failed, see $LOG"; exit 1; }

grep -q "Errors found" "$LOG" && { echo "FAIL, see $LOG"; exit 1; } || { echo "PASS"; exit 0; }
